// ==== verilog/ahb_in_pkg.sv ====
// ----------------------------------------------------------
// AHB input stage package
// Bus encodings, field widths and the address phase record
// ----------------------------------------------------------

package ahb_in_pkg;

  // ----------------------------------------------------------
  // Field widths
  // ----------------------------------------------------------
  localparam int ADDR_W = 32;   // HADDR
  localparam int PROT_W = 4;    // HPROT
  localparam int OFFS_W = 4;    // Wrap offset, covers up to 16 beats

  // HTRANS
  typedef enum logic [1:0] {
    TRN_IDLE   = 2'b00,
    TRN_BUSY   = 2'b01,
    TRN_NONSEQ = 2'b10,
    TRN_SEQ    = 2'b11
  } htrans_t;

  // HBURST
  typedef enum logic [2:0] {
    BUR_SINGLE = 3'b000,
    BUR_INCR   = 3'b001,
    BUR_WRAP4  = 3'b010,
    BUR_INCR4  = 3'b011,
    BUR_WRAP8  = 3'b100,
    BUR_INCR8  = 3'b101,
    BUR_WRAP16 = 3'b110,
    BUR_INCR16 = 3'b111
  } hburst_t;

  // HRESP
  typedef enum logic [1:0] {
    RSP_OKAY  = 2'b00,
    RSP_ERROR = 2'b01,
    RSP_RETRY = 2'b10,
    RSP_SPLIT = 2'b11
  } hresp_t;

  typedef logic [2:0] hsize_t;  // Byte .. 1024 bit

  // One address phase as seen on the port
  typedef struct packed {
    logic              sel;
    htrans_t           trans;
    logic [ADDR_W-1:0] addr;
    logic              write;
    hsize_t            size;
    hburst_t           burst;
    logic [PROT_W-1:0] prot;
    logic              mastlock;
  } addr_ctrl_t;

endpackage

// ==== verilog/ahb_in_ctl_if.sv ====
// ----------------------------------------------------------
// Input stage control strobes
// Carries load and pending state to the datapath blocks
// ----------------------------------------------------------

`timescale 1ns/100ps

interface ahb_in_ctl_if;

  logic load;         // Valid address phase with HREADYS
  logic pend;         // Holding register in use
  logic hready;       // Copy of HREADYS
  logic start_held;   // SEQ loaded while output stage busy

  // Control side
  modport ctl (
    output load, pend, hready, start_held
  );

  // Datapath side
  modport dp (
    input load, pend, hready, start_held
  );

endinterface

// ==== verilog/ahb_in_ctrl.sv ====
// ----------------------------------------------------------
// AHB input stage control
// Address validity, pending transfer state, arbitration
// request and the data phase response to the master
// ----------------------------------------------------------

`timescale 1ns/100ps

module ahb_in_ctrl
  import ahb_in_pkg::*;
(
  input  logic            HCLK,
  input  logic            HRESETn,
  input  logic            HSELS,        // Port select
  input  htrans_t         HTRANSS,      // Transfer type from master
  input  logic            HREADYS,      // Bus ready
  input  logic            active_ip,    // Output stage driving this port
  input  logic            readyout_ip,  // Ready from output stage
  input  hresp_t          resp_ip,      // Response from output stage
  output logic            held_tran,    // Request to arbitration
  output logic            HREADYOUTS,
  output hresp_t          HRESPS,
  ahb_in_ctl_if.ctl       ctl
);

  // ----------------------------------------------------------
  // Address phase
  // ----------------------------------------------------------
  logic addr_valid;   // NONSEQ or SEQ to this port
  logic load;         // Holding register capture
  logic data_valid;   // Data phase of a valid transfer
  logic pend;         // Transfer waiting in holding register
  logic pend_next;

  assign addr_valid = HSELS & HTRANSS[1];   // Bit 1 set for NONSEQ/SEQ
  assign load       = addr_valid & HREADYS;

  // Data phase tracking, advances only with the bus
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (HREADYS)
      data_valid <= addr_valid;
  end

  // ----------------------------------------------------------
  // Pending state
  // ----------------------------------------------------------
  // Set when a transfer arrives and the output stage is not ours,
  // dropped once the output stage completes it
  always_comb
  begin
    if (load && !active_ip)
      pend_next = 1'b1;
    else if (active_ip && readyout_ip)
      pend_next = 1'b0;
    else
      pend_next = pend;   // Back-pressure keeps it
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend <= 1'b0;
    else
      pend <= pend_next;
  end

  assign held_tran = load | pend;   // Direct or held request

  // Strobes for the datapath
  assign ctl.load       = load;
  assign ctl.pend       = pend;
  assign ctl.hready     = HREADYS;
  assign ctl.start_held = load & ~active_ip & (HTRANSS == TRN_SEQ);

  // ----------------------------------------------------------
  // Response to master
  // ----------------------------------------------------------
  always_comb
  begin
    if (!data_valid)
    begin
      HREADYOUTS = 1'b1;        // Idle, busy or not selected
      HRESPS     = RSP_OKAY;
    end
    else if (pend)
    begin
      HREADYOUTS = 1'b0;        // Stall while held
      HRESPS     = RSP_OKAY;
    end
    else
    begin
      HREADYOUTS = readyout_ip;
      HRESPS     = resp_ip;
    end
  end

  // Stalled master stays stalled until the output stage completes
  a_pend_stall : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (pend && data_valid && !HREADYS && !(active_ip && readyout_ip)) |=> !HREADYOUTS
  );

  // Holding register only ever fills from a load
  a_pend_rise : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    $rose(pend) |-> $past(load)
  );

endmodule

// ==== verilog/ahb_hold_reg.sv ====
// ----------------------------------------------------------
// AHB input stage holding register
// Captures an address phase and selects held or direct path
// ----------------------------------------------------------

`timescale 1ns/100ps

module ahb_hold_reg
  import ahb_in_pkg::*;
(
  input  logic        HCLK,
  input  logic        HRESETn,
  input  addr_ctrl_t  in_ac,      // Address phase from master
  ahb_in_ctl_if.dp    ctl,
  output addr_ctrl_t  sel_ac,     // Selected address phase
  output htrans_t     src_trans   // Raw type, for burst recovery
);

  // ----------------------------------------------------------
  // Holding register
  // ----------------------------------------------------------
  addr_ctrl_t held_ac;   // Last loaded address phase

  // Loads on every accepted transfer, held path used only when pending
  always_ff @(posedge HCLK)
  begin
    if (ctl.load)
      held_ac <= in_ac;
  end

  // ----------------------------------------------------------
  // Path select
  // ----------------------------------------------------------
  always_comb
  begin
    if (ctl.pend)
    begin
      sel_ac       = held_ac;
      sel_ac.sel   = 1'b1;          // Held transfer always selected
      sel_ac.trans = TRN_NONSEQ;    // Replayed as a fresh transfer
    end
    else
    begin
      sel_ac = in_ac;               // Straight through
    end
  end

  // Keeps the original SEQ/NONSEQ so an interrupted burst is spotted
  always_comb
  begin
    if (ctl.pend)
      src_trans = held_ac.trans;
    else
      src_trans = in_ac.trans;
  end

  // Held payload is frozen across the whole pending period
  a_held_stable : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (ctl.pend && !ctl.load) |=> $stable(held_ac)
  );

endmodule

// ==== verilog/ahb_burst_term.sv ====
// ----------------------------------------------------------
// AHB input stage early burst termination
// Forces INCR on interrupted bursts and breaks a replayed
// wrap burst into NONSEQ/IDLE at the wrap boundary
// ----------------------------------------------------------

`timescale 1ns/100ps

module ahb_burst_term
  import ahb_in_pkg::*;
(
  input  logic        HCLK,
  input  logic        HRESETn,
  input  addr_ctrl_t  in_ac,      // Address phase from master
  input  addr_ctrl_t  sel_ac,     // After held/direct select
  input  htrans_t     src_trans,  // Raw type of selected transfer
  ahb_in_ctl_if.dp    ctl,
  output htrans_t     trans_o,
  output hburst_t     burst_o
);

  logic              burst_override;  // Burst lost its fixed length
  logic              bound;           // Last beat hit wrap boundary
  logic              bound_next;
  logic              bound_en;
  logic [OFFS_W-1:0] offset_addr;     // Beat index within the wrap
  logic [OFFS_W-1:0] check_addr;      // Offset padded to wrap length

  // ----------------------------------------------------------
  // Burst override
  // ----------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      burst_override <= 1'b0;
    else if (ctl.hready)
    begin
      if (in_ac.trans == TRN_NONSEQ || in_ac.trans == TRN_IDLE)
        burst_override <= 1'b0;       // New burst or end of burst
      else if (ctl.start_held)
        burst_override <= 1'b1;       // Burst interrupted mid-way
    end
  end

  // ----------------------------------------------------------
  // Boundary check
  // ----------------------------------------------------------
  always_comb
  begin
    case (in_ac.size)
      3'b000:  offset_addr = in_ac.addr[3:0];   // Byte
      3'b001:  offset_addr = in_ac.addr[4:1];   // Halfword
      3'b010:  offset_addr = in_ac.addr[5:2];   // Word
      3'b011:  offset_addr = in_ac.addr[6:3];   // Doubleword
      default: offset_addr = in_ac.addr[3:0];   // Wider sizes not scaled
    endcase
  end

  // Upper bits forced high so only the wrapped bits are compared
  always_comb
  begin
    case (in_ac.burst)
      BUR_WRAP4:  check_addr = {2'b11, offset_addr[1:0]};
      BUR_WRAP8:  check_addr = {1'b1, offset_addr[2:0]};
      BUR_WRAP16: check_addr = offset_addr;
      default:    check_addr = '0;          // Non-wrap never matches
    endcase
  end

  assign bound_next = &check_addr;
  assign bound_en   = in_ac.trans[1] & ctl.hready;   // Accepted NONSEQ/SEQ

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound <= 1'b0;
    else if (bound_en)
      bound <= bound_next;
  end

  // ----------------------------------------------------------
  // Output override
  // ----------------------------------------------------------
  // SEQ->NONSEQ and BUSY->IDLE past the boundary
  assign trans_o = (burst_override && bound)
                 ? htrans_t'({sel_ac.trans[1], 1'b0})
                 : sel_ac.trans;

  assign burst_o = (burst_override && (src_trans != TRN_NONSEQ))
                 ? BUR_INCR
                 : sel_ac.burst;

  // Replay of an interrupted burst never claims a fixed length
  a_incr_override : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    ctl.start_held |=> (burst_o == BUR_INCR)
  );

endmodule

// ==== verilog/ahb_in_stage.sv ====
// ----------------------------------------------------------
// AHB bus matrix input stage
// Holds a transfer the output stage cannot take yet and
// replays it, stalling the master meanwhile
// ----------------------------------------------------------

`timescale 1ns/100ps

module ahb_in_stage
  import ahb_in_pkg::*;
(
  input  logic              HCLK,
  input  logic              HRESETn,
  // Master side address phase
  input  logic              HSELS,
  input  logic [ADDR_W-1:0] HADDRS,
  input  htrans_t           HTRANSS,
  input  logic              HWRITES,
  input  hsize_t            HSIZES,
  input  hburst_t           HBURSTS,
  input  logic [PROT_W-1:0] HPROTS,
  input  logic              HMASTLOCKS,
  input  logic              HREADYS,
  // From output stage
  input  logic              active_ip,
  input  logic              readyout_ip,
  input  hresp_t            resp_ip,
  // Response to master
  output logic              HREADYOUTS,
  output hresp_t            HRESPS,
  // To output stage
  output logic              sel_ip,
  output logic [ADDR_W-1:0] addr_ip,
  output htrans_t           trans_ip,
  output logic              write_ip,
  output hsize_t            size_ip,
  output hburst_t           burst_ip,
  output logic [PROT_W-1:0] prot_ip,
  output logic              mastlock_ip,
  output logic              held_tran_ip   // Arbitration request
);

  addr_ctrl_t in_ac;       // Packed master address phase
  addr_ctrl_t sel_ac;      // Held or direct
  htrans_t    src_trans;

  ahb_in_ctl_if u_ctl_if ();

  // ----------------------------------------------------------
  // Pack inputs
  // ----------------------------------------------------------
  assign in_ac.sel      = HSELS;
  assign in_ac.trans    = HTRANSS;
  assign in_ac.addr     = HADDRS;
  assign in_ac.write    = HWRITES;
  assign in_ac.size     = HSIZES;
  assign in_ac.burst    = HBURSTS;
  assign in_ac.prot     = HPROTS;
  assign in_ac.mastlock = HMASTLOCKS;

  ahb_in_ctrl u_ctrl (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .HSELS       (HSELS),
    .HTRANSS     (HTRANSS),
    .HREADYS     (HREADYS),
    .active_ip   (active_ip),
    .readyout_ip (readyout_ip),
    .resp_ip     (resp_ip),
    .held_tran   (held_tran_ip),
    .HREADYOUTS  (HREADYOUTS),
    .HRESPS      (HRESPS),
    .ctl         (u_ctl_if.ctl)
  );

  ahb_hold_reg u_hold (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .in_ac     (in_ac),
    .ctl       (u_ctl_if.dp),
    .sel_ac    (sel_ac),
    .src_trans (src_trans)
  );

  ahb_burst_term u_burst (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .in_ac     (in_ac),
    .sel_ac    (sel_ac),
    .src_trans (src_trans),
    .ctl       (u_ctl_if.dp),
    .trans_o   (trans_ip),   // Type and burst after termination fixup
    .burst_o   (burst_ip)
  );

  // Remaining fields straight from the select
  assign sel_ip      = sel_ac.sel;
  assign addr_ip     = sel_ac.addr;
  assign write_ip    = sel_ac.write;
  assign size_ip     = sel_ac.size;
  assign prot_ip     = sel_ac.prot;
  assign mastlock_ip = sel_ac.mastlock;

endmodule

// ==== bench/tb_ahb_in_model.svh ====
// ----------------------------------------------------------
// AHB input stage reference model
// Cycle model of the stage registers and typed result checks
// ----------------------------------------------------------

`ifndef TB_AHB_IN_MODEL_SVH
`define TB_AHB_IN_MODEL_SVH

// Model copy of the stage registers
logic       m_pend;
logic       m_dvalid;
logic       m_override;
logic       m_bound;
addr_ctrl_t m_held;

// Expected outputs for the current cycle
addr_ctrl_t exp_ac;
logic       exp_held_tran;
logic       exp_ready;
hresp_t     exp_resp;

string test_name;
int    err_cnt;
int    check_cnt;
int    fix_cnt;     // SEQ/BUSY rewritten past a wrap boundary
int    incr_cnt;    // Burst forced to INCR

task automatic reset_model();
  m_pend     = 1'b0;
  m_dvalid   = 1'b0;
  m_override = 1'b0;
  m_bound    = 1'b0;
  m_held     = 'x;    // Never shown before the first load
endtask

function automatic logic addr_valid(addr_ctrl_t ac);
  return ac.sel && (ac.trans == TRN_NONSEQ || ac.trans == TRN_SEQ);
endfunction

// Last beat before the wrap point, offset scaled by transfer size
function automatic logic wrap_end(addr_ctrl_t ac);
  int         shift;
  int         nbits;
  logic [3:0] offs;
  logic [3:0] mask;
  shift = (ac.size <= 3'd3) ? int'(ac.size) : 0;
  offs  = 4'(ac.addr >> shift);
  case (ac.burst)
    BUR_WRAP4:  nbits = 2;
    BUR_WRAP8:  nbits = 3;
    BUR_WRAP16: nbits = 4;
    default:    nbits = 0;     // Incrementing bursts have no wrap point
  endcase
  mask = 4'((1 << nbits) - 1);
  return (nbits != 0) && ((offs & mask) == mask);
endfunction

task automatic predict_outputs();
  htrans_t raw;
  exp_held_tran = (addr_valid(stim) && hready) || m_pend;
  exp_resp      = RSP_OKAY;
  if (!m_dvalid)
    exp_ready = 1'b1;                   // No data phase of ours
  else if (m_pend)
    exp_ready = 1'b0;                   // Master stalled
  else
  begin
    exp_ready = readyout;
    exp_resp  = resp_in;
  end
  if (m_pend)
  begin
    exp_ac       = m_held;
    exp_ac.sel   = 1'b1;
    exp_ac.trans = TRN_NONSEQ;          // Replay
    raw          = m_held.trans;
  end
  else
  begin
    exp_ac = stim;
    raw    = stim.trans;
  end
  if (m_override && raw != TRN_NONSEQ)
  begin
    exp_ac.burst = BUR_INCR;
    incr_cnt++;
  end
  if (m_override && m_bound && exp_ac.trans == TRN_SEQ)
  begin
    exp_ac.trans = TRN_NONSEQ;
    fix_cnt++;
  end
  else if (m_override && m_bound && exp_ac.trans == TRN_BUSY)
  begin
    exp_ac.trans = TRN_IDLE;
    fix_cnt++;
  end
endtask

// State update for one rising edge, inputs still stable
task automatic advance_model();
  logic load;
  load = addr_valid(stim) && hready;
  if (hready)
    m_dvalid = addr_valid(stim);
  if (hready && (stim.trans == TRN_NONSEQ || stim.trans == TRN_IDLE))
    m_override = 1'b0;
  else if (hready && load && !active && stim.trans == TRN_SEQ)
    m_override = 1'b1;                  // Burst broken by a hold
  if (hready && (stim.trans == TRN_NONSEQ || stim.trans == TRN_SEQ))
    m_bound = wrap_end(stim);
  if (load && !active)
    m_pend = 1'b1;
  else if (active && readyout)
    m_pend = 1'b0;
  if (load)
    m_held = stim;
endtask

// Type and burst have their own checks
task automatic compare_ac(input string what, input addr_ctrl_t exp, input addr_ctrl_t act);
  addr_ctrl_t e;
  addr_ctrl_t a;
  e       = exp;
  a       = act;
  e.trans = TRN_IDLE;
  a.trans = TRN_IDLE;
  e.burst = BUR_SINGLE;
  a.burst = BUR_SINGLE;
  check_cnt++;
  if (e !== a)
  begin
    $display("ERROR %s %s: expected %h, actual %h", test_name, what, e, a);
    err_cnt++;
  end
endtask

task automatic compare_trans(input string what, input htrans_t exp, input htrans_t act);
  check_cnt++;
  if (exp !== act)
  begin
    $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
    err_cnt++;
  end
endtask

task automatic compare_burst(input string what, input hburst_t exp, input hburst_t act);
  check_cnt++;
  if (exp !== act)
  begin
    $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
    err_cnt++;
  end
endtask

task automatic compare_resp(input string what, input hresp_t exp, input hresp_t act);
  check_cnt++;
  if (exp !== act)
  begin
    $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
    err_cnt++;
  end
endtask

task automatic compare_bit(input string what, input logic exp, input logic act);
  check_cnt++;
  if (exp !== act)
  begin
    $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
    err_cnt++;
  end
endtask

`endif

// ==== bench/tb_ahb_in_stage.sv ====
// ----------------------------------------------------------
// AHB input stage testbench
// Random address phases checked against a cycle model
// ----------------------------------------------------------

`timescale 1ns/100ps

module tb_ahb_in_stage
  import ahb_in_pkg::*;
();

  localparam int WAIT_LIMIT = 64;   // Cycles allowed for a stall to release

  integer            seed;
  logic              HCLK;
  logic              HRESETn;
  addr_ctrl_t        stim;          // Master address phase
  logic              hready;
  logic              active;
  logic              readyout;
  hresp_t            resp_in;
  logic              hreadyout;
  hresp_t            hresp;
  logic              sel_ip;
  logic [ADDR_W-1:0] addr_ip;
  htrans_t           trans_ip;
  logic              write_ip;
  hsize_t            size_ip;
  hburst_t           burst_ip;
  logic [PROT_W-1:0] prot_ip;
  logic              mastlock_ip;
  logic              held_tran_ip;
  logic              ready_seen;    // HREADYOUTS at the last check
  int                test_cnt;
  int                test_base;

  `include "tb_ahb_in_model.svh"

  ahb_in_stage i_dut (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .HSELS (stim.sel), .HADDRS (stim.addr), .HTRANSS (stim.trans),
    .HWRITES (stim.write), .HSIZES (stim.size), .HBURSTS (stim.burst),
    .HPROTS (stim.prot), .HMASTLOCKS (stim.mastlock), .HREADYS (hready),
    .active_ip (active), .readyout_ip (readyout), .resp_ip (resp_in),
    .HREADYOUTS (hreadyout), .HRESPS (hresp),
    .sel_ip (sel_ip), .addr_ip (addr_ip), .trans_ip (trans_ip),
    .write_ip (write_ip), .size_ip (size_ip), .burst_ip (burst_ip),
    .prot_ip (prot_ip), .mastlock_ip (mastlock_ip), .held_tran_ip (held_tran_ip)
  );

  always #2 HCLK = ~HCLK;   // 4 ns period

  // ----------------------------------------------------------
  // Stimulus and cycle stepping
  // ----------------------------------------------------------
  // act_mode 0 random, 1 always high, 2 mostly low
  task automatic randomize_inputs(input int act_mode, input bit seq_heavy,
                                  input bit wrap_only);
    logic [31:0] r;
    r             = $random(seed);
    stim.sel      = (r[2:0] != 3'b000);    // Mostly selected
    stim.write    = r[3];
    stim.size     = hsize_t'(r[6:4]);
    stim.prot     = r[10:7];
    stim.mastlock = r[11];
    hready        = (r[13:12] != 2'b00);
    resp_in       = hresp_t'(r[15:14]);
    stim.trans    = htrans_t'(r[17:16]);
    if (seq_heavy && r[18])
      stim.trans = TRN_SEQ;
    if (!wrap_only)
      stim.burst = hburst_t'(r[21:19]);
    else if (r[20:19] == 2'b00)
      stim.burst = BUR_WRAP4;
    else if (r[20:19] == 2'b01)
      stim.burst = BUR_WRAP8;
    else
      stim.burst = BUR_WRAP16;
    active    = (act_mode == 1) ? 1'b1 : (act_mode == 2) ? (r[24:23] == 2'b00) : r[22];
    readyout  = (r[29:28] != 2'b00);
    stim.addr = $random(seed);
  endtask

  // Inputs already driven; check mid-cycle, advance at the edge
  task automatic run_cycle();
    @(negedge HCLK);
    predict_outputs();
    check_outputs();
    ready_seen = hreadyout;
    @(posedge HCLK);
    advance_model();
    #1;
  endtask

  task automatic run_random(input int n, input int act_mode,
                            input bit seq_heavy, input bit wrap_only);
    repeat (n)
    begin
      randomize_inputs(act_mode, seq_heavy, wrap_only);
      run_cycle();
    end
  endtask

  // One held transfer, output stage busy then back-pressured
  task automatic replay_once(input int low_cycles, input int bp_cycles);
    int cnt;
    randomize_inputs(0, 1'b0, 1'b0);
    stim.sel   = 1'b1;
    stim.trans = TRN_NONSEQ;
    hready     = 1'b1;
    active     = 1'b0;                     // Forces the hold
    run_cycle();
    cnt        = 0;
    ready_seen = 1'b0;
    while (!ready_seen && cnt < WAIT_LIMIT)
    begin
      randomize_inputs(0, 1'b0, 1'b0);
      hready = 1'b0;                       // Master waits on its data phase
      if (cnt < low_cycles)
        active = 1'b0;
      else
      begin
        active   = 1'b1;
        readyout = (cnt >= low_cycles + bp_cycles);
      end
      run_cycle();
      cnt++;
    end
    if (!ready_seen)
    begin
      $display("Stall not released within %0d cycles in test %s", WAIT_LIMIT, test_name);
      err_cnt++;
    end
  endtask

  task automatic check_outputs();
    addr_ctrl_t act_ac;
    act_ac = '{sel: sel_ip, trans: trans_ip, addr: addr_ip, write: write_ip,
               size: size_ip, burst: burst_ip, prot: prot_ip, mastlock: mastlock_ip};
    compare_ac("address phase", exp_ac, act_ac);
    compare_trans("trans_ip", exp_ac.trans, trans_ip);
    compare_burst("burst_ip", exp_ac.burst, burst_ip);
    compare_resp("HRESPS", exp_resp, hresp);
    compare_bit("HREADYOUTS", exp_ready, hreadyout);
    compare_bit("held_tran_ip", exp_held_tran, held_tran_ip);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_base = err_cnt;
    fix_cnt   = 0;
    incr_cnt  = 0;
  endtask

  task automatic end_test();
    test_cnt++;
    $display("test %-14s %s, errors %0d", test_name,
             (err_cnt == test_base) ? "ok" : "FAILED", err_cnt - test_base);
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial
  begin
    HCLK = 1'b0;
    HRESETn = 1'b0;
    seed = 32'h42c0;
    stim = '{sel: 1'b0, trans: TRN_IDLE, addr: '0, write: 1'b0, size: 3'b000,
             burst: BUR_SINGLE, prot: '0, mastlock: 1'b0};
    hready = 1'b1;
    active = 1'b0;
    readyout = 1'b1;
    resp_in = RSP_OKAY;
    err_cnt = 0;
    check_cnt = 0;
    test_cnt = 0;
    reset_model();
    repeat (5) @(posedge HCLK);
    #1 HRESETn = 1'b1;

    start_test("reset_idle");
    repeat (4) run_cycle();                // Idle inputs after reset
    end_test();
    start_test("pass_through");
    run_random(300, 1, 1'b0, 1'b0);
    end_test();
    start_test("hold_replay");
    repeat (40) replay_once(1 + int'($unsigned($random(seed)) % 6), 0);
    end_test();
    start_test("back_pressure");
    repeat (40) replay_once(int'($unsigned($random(seed)) % 3),
                            1 + int'($unsigned($random(seed)) % 8));
    end_test();
    start_test("burst_override");
    run_random(400, 2, 1'b1, 1'b0);
    if (incr_cnt == 0)
    begin
      $display("Burst was never forced to INCR in test %s", test_name);
      err_cnt++;
    end
    end_test();
    start_test("wrap_boundary");
    run_random(800, 0, 1'b1, 1'b1);
    if (fix_cnt == 0)
    begin
      $display("No transfer crossed a wrap boundary in test %s", test_name);
      err_cnt++;
    end
    end_test();

    $display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+bench
verilog/ahb_in_pkg.sv
verilog/ahb_in_ctl_if.sv
verilog/ahb_in_ctrl.sv
verilog/ahb_hold_reg.sv
verilog/ahb_burst_term.sv
verilog/ahb_in_stage.sv
bench/tb_ahb_in_stage.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the AHB input stage regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f sim.f --top-module tb_ahb_in_stage -Mdir obj_dir

./obj_dir/Vtb_ahb_in_stage | tee sim.log

# Result taken from the log
if grep -q "^Regression passed$" sim.log; then
  exit 0
else
  exit 1
fi
